//--- gpioLed.f
+incdir+hdl
hdl/gpioPkg.sv
hdl/gpioCfgIf.sv
hdl/gpioCsr.sv
hdl/gpioIntervalTimer.sv
hdl/gpioLedDrive.sv
hdl/gpioLedTop.sv
tests/gpioClkGen.sv
tests/gpioLed_chk.sv
tests/gpioLedTb.sv

//--- hdl/gpioCfgIf.sv
// LED settings bundle
`timescale 1ns/1ps
`include "gpio_macros.svh"

interface gpioCfgIf;

	// ------------------------------
	// Register copies
	// ------------------------------
	gpioPkg::ledVecT    ledEn;                       // Enable mask
	gpioPkg::flashModeE flashMode;                   // Shared flash mode
	gpioPkg::dutyT      duty    [`GPIO_LED_NUM];     // PWM duty per LED
	gpioPkg::ivTimerT   ivTimer [`GPIO_LED_NUM];     // Interval divider per LED

	// Register block owns every setting
	modport csrSide
	(
		output ledEn,
		output flashMode,
		output duty,
		output ivTimer
	);

	// Interval timer stage
	modport timerSide
	(
		input ivTimer
	);

	// LED drive stage
	modport driveSide
	(
		input ledEn,
		input flashMode,
		input duty
	);

endinterface

//--- hdl/gpioCsr.sv
// LED controller register block
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioCsr
(
	input  logic             iSysClk,
	input  logic             rstN,
	input  gpioPkg::busDataT wrData,     // Write data
	input  gpioPkg::busAdrsT adrs,       // Shared read and write address
	input  logic             wrEn,       // Write strobe
	output gpioPkg::busDataT rdData,     // Read data, one cycle after the address
	output logic             rdValid,    // Read valid pulse
	gpioCfgIf.csrSide        cfg
);

	// ------------------------------
	// Address decode
	// ------------------------------
	logic       blkSel;
	logic       wrHit;
	logic [7:0] ofs;

	assign blkSel = (adrs[15:8] == `GPIO_BLOCK_ADRS);
	assign wrHit  = wrEn && blkSel;
	assign ofs    = adrs[7:0];

	// ------------------------------
	// Setting registers
	// ------------------------------
	gpioPkg::ledVecT    ledEnR;
	gpioPkg::flashModeE flashModeR;
	gpioPkg::dutyT      dutyR    [`GPIO_LED_NUM];
	gpioPkg::ivTimerT   ivTimerR [`GPIO_LED_NUM];

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			ledEnR     <= '0;
			flashModeR <= gpioPkg::modeStatic;
			for (int i = 0; i < `GPIO_LED_NUM; i++)
			begin
				dutyR[i]    <= '0;
				ivTimerR[i] <= '1;    // Slowest blink
			end
		end
		else if (wrHit)
		begin
			if (ofs == `GPIO_OFS_EN)
				ledEnR <= wrData[`GPIO_LED_NUM-1:0];
			if (ofs == `GPIO_OFS_MODE)
				flashModeR <= gpioPkg::flashModeE'(wrData[1:0]);

			// Per-LED registers sit 4 bytes apart
			for (int i = 0; i < `GPIO_LED_NUM; i++)
			begin
				if (ofs == 8'(`GPIO_OFS_DUTY0 + 4 * i))
					dutyR[i] <= wrData[`GPIO_DUTY_W-1:0];
				if (ofs == 8'(`GPIO_OFS_IV0 + 4 * i))
					ivTimerR[i] <= wrData[`GPIO_IV_W-1:0];
			end
		end
	end

	// Settings out to the later stages
	assign cfg.ledEn     = ledEnR;
	assign cfg.flashMode = flashModeR;
	assign cfg.duty      = dutyR;
	assign cfg.ivTimer   = ivTimerR;

	// ------------------------------
	// Read-back
	// ------------------------------
	gpioPkg::busDataT rdMux;

	// Zero-extended register value, zero when unmapped
	always_comb
	begin
		rdMux = '0;
		case (ofs)
			`GPIO_OFS_EN:
				rdMux = gpioPkg::busDataT'(ledEnR);
			`GPIO_OFS_MODE:
				rdMux = gpioPkg::busDataT'(flashModeR);
			default:
			begin
				for (int i = 0; i < `GPIO_LED_NUM; i++)
				begin
					if (ofs == 8'(`GPIO_OFS_DUTY0 + 4 * i))
						rdMux = gpioPkg::busDataT'(dutyR[i]);
					if (ofs == 8'(`GPIO_OFS_IV0 + 4 * i))
						rdMux = gpioPkg::busDataT'(ivTimerR[i]);
				end
			end
		endcase
	end

	// Any in-block address gives a result, write or not
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			rdValid <= 1'b0;
		else
			rdValid <= blkSel;
	end

	always_ff @(posedge iSysClk)
	begin
		if (blkSel)
			rdData <= rdMux;    // Held until the next in-block access
	end

endmodule

//--- hdl/gpioIntervalTimer.sv
// Blink phase interval timers
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioIntervalTimer
(
	input  logic            iSysClk,
	input  logic            rstN,
	gpioCfgIf.timerSide     cfg,
	output gpioPkg::ledVecT blinkPhase    // One phase bit per LED
);

	// ------------------------------
	// Down-counters
	// ------------------------------
	gpioPkg::ivTimerT cntR [`GPIO_LED_NUM];
	gpioPkg::ledVecT  phaseR;

	// Phase toggles every divider + 1 cycles
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			phaseR <= '0;
			for (int i = 0; i < `GPIO_LED_NUM; i++)
				cntR[i] <= '1;    // Matches the divider reset value
		end
		else
		begin
			for (int i = 0; i < `GPIO_LED_NUM; i++)
			begin
				if (cntR[i] == '0)
				begin
					cntR[i]   <= cfg.ivTimer[i];    // Reload picks up a new divider
					phaseR[i] <= ~phaseR[i];
				end
				else if (cntR[i] > cfg.ivTimer[i])
				begin
					// Divider shrank below the count, reload early
					cntR[i] <= cfg.ivTimer[i];
				end
				else
				begin
					cntR[i] <= cntR[i] - 1'b1;
				end
			end
		end
	end

	assign blinkPhase = phaseR;

endmodule

//--- hdl/gpioLedDrive.sv
// PWM and LED output drive
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioLedDrive
(
	input  logic            iSysClk,
	input  logic            rstN,
	gpioCfgIf.driveSide     cfg,
	input  gpioPkg::ledVecT blinkPhase,
	output gpioPkg::ledVecT ledOut       // Registered LED pins
);

	// ------------------------------
	// PWM
	// ------------------------------
	gpioPkg::dutyT   pwmCnt;
	gpioPkg::ledVecT pwmBit;

	// Free running, wraps every 256 cycles
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			pwmCnt <= '0;
		else
			pwmCnt <= pwmCnt + 1'b1;
	end

	// High for duty cycles out of 256
	always_comb
	begin
		for (int i = 0; i < `GPIO_LED_NUM; i++)
			pwmBit[i] = (pwmCnt < cfg.duty[i]);
	end

	// ------------------------------
	// Mode select
	// ------------------------------
	gpioPkg::ledVecT modeTerm;

	always_comb
	begin
		case (cfg.flashMode)
			gpioPkg::modeStatic:   modeTerm = '1;
			gpioPkg::modeBlink:    modeTerm = blinkPhase;
			gpioPkg::modeDim:      modeTerm = pwmBit;
			gpioPkg::modeDimBlink: modeTerm = blinkPhase & pwmBit;
			default:               modeTerm = '0;
		endcase
	end

	// Output register, enable gates every mode
	gpioPkg::ledVecT ledR;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			ledR <= '0;
		else
			ledR <= cfg.ledEn & modeTerm;
	end

	assign ledOut = ledR;

endmodule

//--- hdl/gpioLedTop.sv
// LED controller top level
`timescale 1ns/1ps

module gpioLedTop
(
	// Clock and reset
	input  logic             iSysClk,
	input  logic             rstN,

	// ------------------------------
	// Bus slave port
	// ------------------------------
	input  gpioPkg::busDataT wrData,
	input  gpioPkg::busAdrsT adrs,
	input  logic             wrEn,
	output gpioPkg::busDataT rdData,
	output logic             rdValid,

	// LED pins
	output gpioPkg::ledVecT  ledOut
);

	// Settings from the register block
	gpioCfgIf cfgBus ();

	gpioPkg::ledVecT blinkPhase;    // Timer to drive stage

	// ------------------------------
	// Stage 1, registers
	// ------------------------------
	gpioCsr uCsr
	(
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.wrData  (wrData),
		.adrs    (adrs),
		.wrEn    (wrEn),
		.rdData  (rdData),
		.rdValid (rdValid),
		.cfg     (cfgBus.csrSide)
	);

	// ------------------------------
	// Stage 2, blink timers
	// ------------------------------
	gpioIntervalTimer uTimer
	(
		.iSysClk    (iSysClk),
		.rstN       (rstN),
		.cfg        (cfgBus.timerSide),
		.blinkPhase (blinkPhase)
	);

	// ------------------------------
	// Stage 3, LED drive
	// ------------------------------
	gpioLedDrive uDrive
	(
		.iSysClk    (iSysClk),
		.rstN       (rstN),
		.cfg        (cfgBus.driveSide),
		.blinkPhase (blinkPhase),
		.ledOut     (ledOut)
	);

endmodule

//--- hdl/gpioPkg.sv
// LED controller shared types

package gpioPkg;

`include "gpio_macros.svh"

	// ------------------------------
	// Bus side
	// ------------------------------
	typedef logic [`GPIO_BUS_W-1:0] busDataT;    // Read and write data
	typedef logic [`GPIO_BUS_W-1:0] busAdrsT;    // Block select in 15:8, offset in 7:0

	// ------------------------------
	// LED settings
	// ------------------------------
	// One bit per LED, bit 0 is LED 0
	typedef logic [`GPIO_LED_NUM-1:0] ledVecT;

	typedef logic [`GPIO_DUTY_W-1:0] dutyT;      // High cycles out of 256
	typedef logic [`GPIO_IV_W-1:0] ivTimerT;     // Half blink period minus one

	// Flash mode shared by all LEDs
	typedef enum logic [1:0]
	{
		modeStatic   = 2'b00,    // Follows enable only
		modeBlink    = 2'b01,    // Blink phase
		modeDim      = 2'b10,    // PWM only
		modeDimBlink = 2'b11     // Blink phase and PWM
	} flashModeE;

endpackage

//--- hdl/gpio_macros.svh
// LED controller widths and register map
`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

// ------------------------------
// Widths
// ------------------------------
`define GPIO_LED_NUM     5      // External LEDs
`define GPIO_DUTY_W      8      // PWM duty
`define GPIO_IV_W        16     // Interval divider
`define GPIO_BUS_W       32     // Bus address and data

// ------------------------------
// Block select, address bits 15 to 8
// ------------------------------
`define GPIO_BLOCK_ADRS  8'h01

// ------------------------------
// Register offsets, address bits 7 to 0
// ------------------------------
`define GPIO_OFS_EN      8'h00  // Enable mask
`define GPIO_OFS_MODE    8'h04  // Shared flash mode
`define GPIO_OFS_DUTY0   8'h08  // Duty of LED 0, then every 4 up to 8'h18
`define GPIO_OFS_IV0     8'h1C  // Divider of LED 0, then every 4 up to 8'h2C

`endif

//--- tests/gpioClkGen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module gpioClkGen
(
	output logic sysClk,
	output logic rstN
);

	localparam int halfPeriod = 4;    // 8 ns period

	initial
		sysClk = 1'b0;

	always #halfPeriod sysClk = ~sysClk;

	// Held low for 5 rising edges
	initial
	begin
		rstN = 1'b0;
		repeat (5) @(posedge sysClk);
		#1 rstN = 1'b1;
	end

endmodule

//--- tests/gpioLedTb.sv
// LED controller testbench
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioLedTb;

	localparam logic [7:0] blkOwn   = `GPIO_BLOCK_ADRS;
	localparam logic [7:0] blkOther = 8'h02;
	localparam int         regNum   = 2 + 2 * `GPIO_LED_NUM;
	// Reset, CSR tests, static, dim, blink, dimmed blink
	localparam int testCycles = 5 + 160 + 10 + 270 + 410 + 1650;
	localparam int cycleLimit = 16 * testCycles;    // Wide margin

	logic             sysClk;
	logic             rstN;
	gpioPkg::busDataT wrData;
	gpioPkg::busAdrsT adrs;
	logic             wrEn;
	gpioPkg::busDataT rdData;
	logic             rdValid;
	gpioPkg::ledVecT  ledOut;

	logic [31:0]      lfsrState = 32'h151c;
	int               cycleCnt  = 0;
	int               errCount  = 0;
	gpioPkg::busDataT expReg  [regNum];           // Expected register contents
	int               winLen  [`GPIO_LED_NUM];    // Count window per LED
	int               highCnt [`GPIO_LED_NUM];

	gpioClkGen uClk (.sysClk(sysClk), .rstN(rstN));

	gpioLedTop DUT
	(
		.iSysClk (sysClk),
		.rstN    (rstN),
		.wrData  (wrData),
		.adrs    (adrs),
		.wrEn    (wrEn),
		.rdData  (rdData),
		.rdValid (rdValid),
		.ledOut  (ledOut)
	);

	// ------------------------------
	// Helpers
	// ------------------------------
	// Galois LFSR, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int b = 0; b < n; b++)
		begin
			val = {val[30:0], lfsrState[0]};
			lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
		end
		return val;
	endfunction

	// Register index order is enable, mode, duties, dividers
	function automatic logic [7:0] regOfs(input int idx);
		if (idx == 0)
			return `GPIO_OFS_EN;
		if (idx == 1)
			return `GPIO_OFS_MODE;
		if (idx < 2 + `GPIO_LED_NUM)
			return `GPIO_OFS_DUTY0 + 8'(4 * (idx - 2));
		return `GPIO_OFS_IV0 + 8'(4 * (idx - 2 - `GPIO_LED_NUM));
	endfunction

	function automatic gpioPkg::busDataT regMask(input int idx);
		if (idx == 0)
			return (1 << `GPIO_LED_NUM) - 1;
		if (idx == 1)
			return 32'h3;
		if (idx < 2 + `GPIO_LED_NUM)
			return (1 << `GPIO_DUTY_W) - 1;
		return (1 << `GPIO_IV_W) - 1;
	endfunction

	task automatic waitClk();
		@(posedge sysClk);
		#1;
	endtask

	task automatic raiseError(input string msg);
		errCount++;
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkData(input gpioPkg::busDataT got, input gpioPkg::busDataT exp,
		input string what);
		if (got !== exp)
			raiseError($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkLed(input gpioPkg::ledVecT got, input gpioPkg::ledVecT exp,
		input string what);
		if (got !== exp)
			raiseError($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// ------------------------------
	// Bus access
	// ------------------------------
	task automatic busWrite(input logic [7:0] blk, input logic [7:0] ofs,
		input gpioPkg::busDataT data);
		adrs   = {16'h0, blk, ofs};
		wrData = data;
		wrEn   = 1'b1;
		waitClk();
		wrEn   = 1'b0;
		wrData = '0;
		adrs   = '0;    // Idle outside the block
	endtask

	task automatic busRead(input logic [7:0] blk, input logic [7:0] ofs,
		output gpioPkg::busDataT data);
		int waitCnt;
		adrs = {16'h0, blk, ofs};
		waitClk();
		adrs = '0;
		waitCnt = 0;
		while (!rdValid && waitCnt < 4)
		begin
			waitClk();
			waitCnt++;
		end
		if (!rdValid)
			raiseError($sformatf("Read of offset %h got no rdValid from the DUT", ofs));
		data = rdData;
		waitClk();
		if (rdValid)
			raiseError($sformatf("rdValid stayed high for more than one cycle at %h", ofs));
	endtask

	task automatic readNoValid(input logic [7:0] blk, input logic [7:0] ofs);
		adrs = {16'h0, blk, ofs};
		waitClk();
		adrs = '0;
		repeat (3)
		begin
			if (rdValid)
				raiseError($sformatf("Read with foreign block %h gave an rdValid", blk));
			waitClk();
		end
	endtask

	// High cycles per LED over its own window
	task automatic countHigh();
		int maxLen;
		maxLen = 0;
		for (int i = 0; i < `GPIO_LED_NUM; i++)
		begin
			highCnt[i] = 0;
			if (winLen[i] > maxLen)
				maxLen = winLen[i];
		end
		for (int c = 0; c < maxLen; c++)
		begin
			waitClk();
			for (int i = 0; i < `GPIO_LED_NUM; i++)
				if (c < winLen[i] && ledOut[i])
					highCnt[i]++;
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic csrReadBack();
		gpioPkg::busDataT val;
		for (int r = 0; r < regNum; r++)
		begin
			busRead(blkOwn, regOfs(r), val);
			checkData(val, (r >= 2 + `GPIO_LED_NUM) ? 32'hFFFF : 32'h0, "Reset value");
		end
		for (int r = 0; r < regNum; r++)
		begin
			val = takeBits(32);
			expReg[r] = val & regMask(r);
			busWrite(blkOwn, regOfs(r), val);
		end
		for (int r = 0; r < regNum; r++)
		begin
			busRead(blkOwn, regOfs(r), val);
			checkData(val, expReg[r], $sformatf("Register at %h", regOfs(r)));
		end
		busRead(blkOwn, 8'h30, val);
		checkData(val, '0, "Unmapped offset 30");
		busRead(blkOwn, 8'h02, val);
		checkData(val, '0, "Unmapped offset 02");
		// Write data never comes back from an unmapped offset
		busWrite(blkOwn, 8'h30, takeBits(32) | 32'h1);
		checkData(rdData, '0, "Result of a write to unmapped offset 30");
	endtask

	task automatic blockDecode();
		gpioPkg::busDataT val;
		for (int r = 0; r < regNum; r++)
			busWrite(blkOther, regOfs(r), ~expReg[r]);
		for (int r = 0; r < regNum; r++)
		begin
			busRead(blkOwn, regOfs(r), val);
			checkData(val, expReg[r], "Register after foreign write");
		end
		readNoValid(blkOther, `GPIO_OFS_EN);
		readNoValid(8'h81, `GPIO_OFS_IV0);
	endtask

	task automatic staticMode();
		gpioPkg::ledVecT mask;
		busWrite(blkOwn, `GPIO_OFS_MODE, gpioPkg::busDataT'(gpioPkg::modeStatic));
		repeat (3)
		begin
			busWrite(blkOwn, `GPIO_OFS_EN, '0);
			waitClk();
			mask = takeBits(`GPIO_LED_NUM);
			busWrite(blkOwn, `GPIO_OFS_EN, mask);
			checkLed(ledOut, '0, "ledOut before the mask lands");
			waitClk();    // 2 cycles after the write is driven
			checkLed(ledOut, mask, "ledOut in static mode");
		end
	endtask

	task automatic dimMode();
		int duty [`GPIO_LED_NUM];
		for (int i = 0; i < `GPIO_LED_NUM; i++)
		begin
			duty[i] = takeBits(`GPIO_DUTY_W);
			busWrite(blkOwn, regOfs(2 + i), duty[i]);
			winLen[i] = 256;
		end
		busWrite(blkOwn, `GPIO_OFS_EN, 32'h1F);
		busWrite(blkOwn, `GPIO_OFS_MODE, gpioPkg::busDataT'(gpioPkg::modeDim));
		repeat (3) waitClk();
		countHigh();
		for (int i = 0; i < `GPIO_LED_NUM; i++)
			checkData(highCnt[i], duty[i], $sformatf("Dim LED %0d high cycles", i));
	endtask

	task automatic blinkMode();
		int div [`GPIO_LED_NUM];
		int off;
		off = takeBits(3) % `GPIO_LED_NUM;    // Disabled LED
		for (int i = 0; i < `GPIO_LED_NUM; i++)
		begin
			div[i] = takeBits(6);
			busWrite(blkOwn, regOfs(2 + `GPIO_LED_NUM + i), div[i]);
			winLen[i] = 2 * (div[i] + 1) * 2;
		end
		busWrite(blkOwn, `GPIO_OFS_EN, 32'h1F & ~(32'h1 << off));
		busWrite(blkOwn, `GPIO_OFS_MODE, gpioPkg::busDataT'(gpioPkg::modeBlink));
		repeat (140) waitClk();    // Counters settle on the new dividers
		countHigh();
		for (int i = 0; i < `GPIO_LED_NUM; i++)
			checkData(highCnt[i], (i == off) ? 0 : (div[i] + 1) * 2,
				$sformatf("Blink LED %0d high cycles", i));
	endtask

	task automatic dimBlinkMode();
		int duty [`GPIO_LED_NUM];
		for (int i = 0; i < `GPIO_LED_NUM; i++)
		begin
			duty[i] = takeBits(`GPIO_DUTY_W);
			busWrite(blkOwn, regOfs(2 + i), duty[i]);
			busWrite(blkOwn, regOfs(2 + `GPIO_LED_NUM + i), 511);
			winLen[i] = 1024;
		end
		busWrite(blkOwn, `GPIO_OFS_EN, 32'h1F);
		busWrite(blkOwn, `GPIO_OFS_MODE, gpioPkg::busDataT'(gpioPkg::modeDimBlink));
		repeat (600) waitClk();
		countHigh();
		for (int i = 0; i < `GPIO_LED_NUM; i++)
			checkData(highCnt[i], 2 * duty[i], $sformatf("Dimmed blink LED %0d", i));
	endtask

	// ------------------------------
	// Run control
	// ------------------------------
	always @(posedge sysClk)
	begin
		cycleCnt++;
		if (cycleCnt > cycleLimit)
		begin
			$display("Timeout after %0d cycles with the tests still running", cycleCnt);
			$display("test failed");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		wrData = '0;
		adrs   = '0;
		wrEn   = 1'b0;
		wait (rstN === 1'b1);
		waitClk();
		csrReadBack();
		blockDecode();
		staticMode();
		dimMode();
		blinkMode();
		dimBlinkMode();
		if (errCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- tests/gpioLed_chk.sv
// Bus and LED assertions
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioLedChk
(
	input logic             iSysClk,
	input logic             rstN,
	input gpioPkg::busAdrsT adrs,
	input logic             rdValid,
	input gpioPkg::ledVecT  ledEn,      // Enable mask register
	input gpioPkg::ledVecT  ledOut
);

	// ------------------------------
	// Read-valid pulse
	// ------------------------------
	// Only an in-block address on the previous edge gives a result
	rdValidFromBlock: assert property (@(posedge iSysClk) disable iff (!rstN)
		rdValid |-> $past(adrs[15:8] == `GPIO_BLOCK_ADRS))
	else
		$error("rdValid seen without an in-block address one cycle before");

	rdValidLowInReset: assert property (@(posedge iSysClk)
		!rstN |-> !rdValid)
	else
		$error("rdValid high while reset is asserted");

	// ------------------------------
	// LED outputs
	// ------------------------------
	// Zero mask register clears the pins at the next edge
	ledOffWhenMasked: assert property (@(posedge iSysClk) disable iff (!rstN)
		(ledEn == '0) |=> (ledOut == '0))
	else
		$error("ledOut not zero after the enable mask went to zero");

endmodule

bind gpioLedTop gpioLedChk uChk
(
	.iSysClk (iSysClk),
	.rstN    (rstN),
	.adrs    (adrs),
	.rdValid (rdValid),
	.ledEn   (cfgBus.ledEn),
	.ledOut  (ledOut)
);
